// ==== Bender.yml ====
package:
  name: dino_game

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dino_pkg.sv
      - common/hitbox_if.sv
      - hdl/cmd_input.sv
      - game/runner_physics.sv
      - game/obstacle_mover.sv
      - game/collision_score.sv
      - hdl/score_display.sv
      - hdl/dino_game_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/dino_game_assert.sv
      - dv/dino_game_tb.sv

// ==== common/dino_defines.svh ====
`ifndef DINO_DEFINES_SVH
`define DINO_DEFINES_SVH

// Play field in pixels
`define SCREEN_W 320
`define GROUND_Y 109
`define PLAYER_X 52

// Jump physics in pixels per game tick
`define JUMP_FORCE 10
`define GRAVITY 1
`define DUCK_TICKS 32

// Player hitbox relative to the sprite corner
`define PLAYER_HB_X_OFS 6
`define PLAYER_HB_W 20
`define PLAYER_HB_TOP(duck) ((duck) ? 16 : 2)
`define PLAYER_HB_H(duck) ((duck) ? 16 : 28)

// Obstacle box and its two lanes
`define OBS_SIZE 16
`define OBS_Y_HIGH 102
`define OBS_Y_LOW 122
`define OBS_SPAWN_SPREAD 100

// Timing in clock cycles
`define GAME_TICK_CYCLES 64
`define OBS_STEP_CYCLES 64    // At speed level 0
`define UART_OS_DIV 27        // One 16x oversampling tick

// Serial command bytes
`define CMD_JUMP 8'h4A        // 'J'
`define CMD_DUCK 8'h44        // 'D'
`define CMD_RESTART 8'h49     // 'I'

`endif

// ==== common/dino_pkg.sv ====
`default_nettype none

package dino_pkg;

	typedef logic [8:0] xpos_t;    // Horizontal pixel position
	typedef logic [7:0] ypos_t;    // Vertical pixel position, grows downward

	typedef logic [15:0] score_t;
	typedef logic [7:0] speed_t;

	// Segment a is bit 0, a low bit lights the segment
	typedef logic [6:0] seg7_t;

	// Player vertical motion
	typedef enum logic [1:0] {
		RUNNING    = 2'd0,
		ASCENDING  = 2'd1,
		DESCENDING = 2'd2
	} jump_state_e;

	// 8N1 receiver
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

endpackage

`default_nettype wire

// ==== common/hitbox_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Positions the collision stage checks every cycle
interface hitbox_if;

	dino_pkg::ypos_t player_y;      // Top of the player sprite
	logic ducking;
	dino_pkg::xpos_t obstacle_x;    // Left edge of the obstacle
	dino_pkg::ypos_t obstacle_y;

	modport player (output player_y, output ducking);

	modport obstacle (output obstacle_x, output obstacle_y);

	modport judge (input player_y, input ducking, input obstacle_x, input obstacle_y);

endinterface

`default_nettype wire

// ==== dv/dino_game_assert.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dino_defines.svh"

module dino_game_assert (
	input wire Clock,
	input wire rst_n,
	input wire i_jump,
	input wire i_duck,
	input wire i_ducking,
	input wire i_game_over,
	input wire i_restart,
	input wire i_led_jump,
	input wire i_led_duck,
	input wire dino_pkg::ypos_t i_player_y,
	input wire dino_pkg::xpos_t i_obstacle_x,
	input wire dino_pkg::ypos_t i_obstacle_y,
	input wire dino_pkg::seg7_t i_hex0,
	input wire dino_pkg::seg7_t i_hex1,
	input wire dino_pkg::seg7_t i_hex2,
	input wire dino_pkg::seg7_t i_hex3,
	input wire dino_pkg::seg7_t i_hex4,
	input wire dino_pkg::seg7_t i_hex5
);

	localparam dino_pkg::ypos_t GROUND = dino_pkg::ypos_t'(`GROUND_Y);
	localparam int AIR_CYCLES = (2 * `JUMP_FORCE + 2) * `GAME_TICK_CYCLES;
	localparam int X_MAX = `SCREEN_W - `OBS_SIZE + `OBS_SPAWN_SPREAD - 1;

	int unsigned fail_count = 0;
	logic jump_req;
	logic any_cmd;
	int score_shown;
	int high_shown;
	logic hex_valid;

	// Active-low digit patterns, -1 for anything else
	function automatic int seg_value(input dino_pkg::seg7_t seg);
		case (seg)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			7'b0000000: return 8;
			7'b0010000: return 9;
			default: return -1;
		endcase
	endfunction

	assign jump_req = i_jump && !i_duck && !i_ducking && !i_game_over && (i_player_y == GROUND);
	assign any_cmd = i_led_jump || i_led_duck || i_restart;

	always_comb begin
		score_shown = seg_value(i_hex2) * 100 + seg_value(i_hex1) * 10 + seg_value(i_hex0);
		high_shown = seg_value(i_hex5) * 100 + seg_value(i_hex4) * 10 + seg_value(i_hex3);
		hex_valid = seg_value(i_hex0) >= 0 && seg_value(i_hex1) >= 0 && seg_value(i_hex2) >= 0
			&& seg_value(i_hex3) >= 0 && seg_value(i_hex4) >= 0 && seg_value(i_hex5) >= 0;
	end

	a_cmd_single: assert property (@(posedge Clock) disable iff (!rst_n)
		any_cmd |=> !any_cmd)
		else begin fail_count++; $error("command strobe longer than one cycle"); end

	a_above_ground: assert property (@(posedge Clock) disable iff (!rst_n)
		i_player_y <= GROUND)
		else begin fail_count++; $error("player below ground, y=%0d", i_player_y); end

	a_jump_lifts: assert property (@(posedge Clock) disable iff (!rst_n || i_game_over)
		jump_req |-> ##[1:`GAME_TICK_CYCLES + 1] (i_player_y < GROUND))
		else begin fail_count++; $error("accepted jump did not leave the ground"); end

	a_jump_lands: assert property (@(posedge Clock) disable iff (!rst_n || i_game_over)
		$fell(i_player_y == GROUND) |-> ##[1:AIR_CYCLES] (i_player_y == GROUND))
		else begin fail_count++; $error("player did not land in time"); end

	a_duck_blocks_jump: assert property (@(posedge Clock) disable iff (!rst_n)
		i_jump && i_ducking |=> i_player_y == GROUND)
		else begin fail_count++; $error("jump taken while ducking"); end

	a_obstacle_range: assert property (@(posedge Clock) disable iff (!rst_n)
		!i_game_over |-> i_obstacle_x <= dino_pkg::xpos_t'(X_MAX))
		else begin fail_count++; $error("obstacle x out of range: %0d", i_obstacle_x); end

	a_obstacle_lane: assert property (@(posedge Clock) disable iff (!rst_n)
		i_obstacle_y == dino_pkg::ypos_t'(`OBS_Y_HIGH) ||
		i_obstacle_y == dino_pkg::ypos_t'(`OBS_Y_LOW))
		else begin fail_count++; $error("obstacle off its lanes, y=%0d", i_obstacle_y); end

	a_game_over_holds: assert property (@(posedge Clock) disable iff (!rst_n)
		i_game_over && !i_restart |=> i_game_over)
		else begin fail_count++; $error("game over dropped without restart"); end

	a_score_holds: assert property (@(posedge Clock) disable iff (!rst_n)
		i_game_over && !i_restart |=> $stable({i_hex2, i_hex1, i_hex0}))
		else begin fail_count++; $error("score digits changed after game over"); end

	a_high_covers_score: assert property (@(posedge Clock) disable iff (!rst_n)
		i_game_over |-> high_shown >= score_shown)
		else begin fail_count++; $error("high score %0d below score %0d", high_shown,
			score_shown); end

	a_restart_clears: assert property (@(posedge Clock) disable iff (!rst_n)
		i_game_over && i_restart |=> score_shown == 0)
		else begin fail_count++; $error("score not zero after restart"); end

	a_hex_valid: assert property (@(posedge Clock) disable iff (!rst_n)
		hex_valid)
		else begin fail_count++; $error("hex output is no digit pattern"); end

endmodule

bind dino_game_top dino_game_assert u_dino_game_assert (
	.Clock        (Clock),
	.rst_n        (rst_n),
	.i_jump       (jump),
	.i_duck       (duck),
	.i_ducking    (hb_bus.ducking),
	.i_game_over  (o_game_over),
	.i_restart    (o_led_restart),
	.i_led_jump   (o_led_jump),
	.i_led_duck   (o_led_duck),
	.i_player_y   (o_player_y),
	.i_obstacle_x (o_obstacle_x),
	.i_obstacle_y (o_obstacle_y),
	.i_hex0       (o_hex0),
	.i_hex1       (o_hex1),
	.i_hex2       (o_hex2),
	.i_hex3       (o_hex3),
	.i_hex4       (o_hex4),
	.i_hex5       (o_hex5)
);

`default_nettype wire

// ==== dv/dino_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dino_defines.svh"

module dino_game_tb;

	localparam int BIT_CYCLES = 16 * `UART_OS_DIV;    // One UART bit
	localparam int FRAME_CYCLES = 10 * BIT_CYCLES;      // Start, 8 data, stop
	localparam int NUM_BYTES = 5;
	// Bytes sent, 40 ticks per jump and duck, obstacle steps, a quarter margin
	localparam int TIMEOUT_CYCLES = (NUM_BYTES * FRAME_CYCLES
		+ 2 * 40 * `GAME_TICK_CYCLES + 4000 * `OBS_STEP_CYCLES) * 5 / 4;
	localparam int DODGE_X = `PLAYER_X + `PLAYER_HB_X_OFS + `PLAYER_HB_W + 2;    // Just clear of the player box
	localparam dino_pkg::seg7_t SEG_ONE = 7'b1111001;    // Active low, segments b and c

	logic Clock;
	logic rst_n;
	logic uart_rx;
	logic key_jump;
	logic key_duck;
	wire dino_pkg::seg7_t hex0;
	wire dino_pkg::seg7_t hex1;
	wire dino_pkg::seg7_t hex2;
	wire dino_pkg::seg7_t hex3;
	wire dino_pkg::seg7_t hex4;
	wire dino_pkg::seg7_t hex5;
	wire game_over;
	wire led_jump;
	wire led_duck;
	wire led_restart;
	wire dino_pkg::ypos_t player_y;
	wire dino_pkg::xpos_t obstacle_x;
	wire dino_pkg::ypos_t obstacle_y;

	int mismatches = 0;
	int jump_pulses = 0;
	int duck_pulses = 0;
	int restart_pulses = 0;
	int cycle_cnt;

	dino_game_top i_dino_game_top (
		.Clock         (Clock),
		.rst_n         (rst_n),
		.i_uart_rx     (uart_rx),
		.i_key_jump    (key_jump),
		.i_key_duck    (key_duck),
		.o_hex0        (hex0),
		.o_hex1        (hex1),
		.o_hex2        (hex2),
		.o_hex3        (hex3),
		.o_hex4        (hex4),
		.o_hex5        (hex5),
		.o_game_over   (game_over),
		.o_led_jump    (led_jump),
		.o_led_duck    (led_duck),
		.o_led_restart (led_restart),
		.o_player_y    (player_y),
		.o_obstacle_x  (obstacle_x),
		.o_obstacle_y  (obstacle_y)
	);

	always #2 Clock = ~Clock;

	// Command strobes last one cycle, so one sample each
	always @(negedge Clock) begin
		if (rst_n) begin
			jump_pulses += led_jump;
			duck_pulses += led_duck;
			restart_pulses += led_restart;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge Clock);
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected) begin
			mismatches++;
			$display("MISMATCH time=%0t %s expected=%0d got=%0d", $time, name, expected, actual);
		end
	endtask

	// 8N1, LSB first
	task automatic send_byte(input logic [7:0] data);
		uart_rx = 1'b0;
		wait_cycles(BIT_CYCLES);
		for (int i = 0; i < 8; i++) begin
			uart_rx = data[i];
			wait_cycles(BIT_CYCLES);
		end
		uart_rx = 1'b1;
		wait_cycles(BIT_CYCLES);
	endtask

	task automatic check_command(input logic [7:0] data);
		int jump_start;
		int duck_start;
		int restart_start;
		jump_start = jump_pulses;
		duck_start = duck_pulses;
		restart_start = restart_pulses;
		send_byte(data);
		wait_cycles(BIT_CYCLES);    // Eleventh bit time after the start edge
		check_value("o_led_jump pulses", jump_pulses - jump_start,
			(data == `CMD_JUMP) ? 1 : 0);
		check_value("o_led_duck pulses", duck_pulses - duck_start,
			(data == `CMD_DUCK) ? 1 : 0);
		check_value("o_led_restart pulses", restart_pulses - restart_start,
			(data == `CMD_RESTART) ? 1 : 0);
	endtask

	function automatic logic [7:0] random_other_byte();
		logic [7:0] b;
		b = 8'($urandom);
		while (b == `CMD_JUMP || b == `CMD_DUCK || b == `CMD_RESTART)
			b = 8'($urandom);
		return b;
	endfunction

	task automatic finish_run(input logic timed_out);
		int assert_fails;
		assert_fails = i_dino_game_top.u_dino_game_assert.fail_count;
		$display("Error count: %0d mismatches, %0d assertion failures, %0d timeouts",
			mismatches, assert_fails, timed_out);
		if (!timed_out && mismatches == 0 && assert_fails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge Clock);
			cycle_cnt++;
		end
		$display("ERROR: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		finish_run(1'b1);
	end

	initial begin
		void'($urandom(32'h39bb));
		Clock = 1'b0;
		rst_n = 1'b0;
		uart_rx = 1'b1;    // Line idles high
		key_jump = 1'b0;
		key_duck = 1'b0;
		wait_cycles(16);
		rst_n = 1'b1;
		wait_cycles(4);

		// Serial jump, then wait for the landing
		check_command(`CMD_JUMP);
		while (player_y != dino_pkg::ypos_t'(`GROUND_Y))
			@(negedge Clock);

		// Duck, then try to jump out of it with the key
		check_command(`CMD_DUCK);
		key_jump = 1'b1;
		wait_cycles(4 * `GAME_TICK_CYCLES);
		key_jump = 1'b0;

		// Duck under the first obstacle, still in the high lane
		while (obstacle_x > DODGE_X)
			@(negedge Clock);
		key_duck = 1'b1;
		wait_cycles(2);
		key_duck = 1'b0;
		while (obstacle_x > `PLAYER_X)
			@(negedge Clock);
		while (obstacle_x <= `PLAYER_X)
			@(negedge Clock);
		check_value("o_game_over", game_over, 0);
		check_value("o_hex0", hex0, SEG_ONE);

		// Held key lands the player in the obstacle sooner or later
		key_jump = 1'b1;
		while (!game_over)
			@(negedge Clock);
		key_jump = 1'b0;

		// Game over must hold meanwhile
		repeat (2) check_command(random_other_byte());

		check_command(`CMD_RESTART);
		check_value("o_game_over", game_over, 0);

		// Idle while the next obstacle comes in
		while (!game_over)
			@(negedge Clock);
		wait_cycles(16);
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

// ==== game/collision_score.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dino_defines.svh"

module collision_score (
	input  wire Clock,
	input  wire rst_n,
	input  wire i_restart,
	hitbox_if.judge hb,
	output logic o_game_over,
	output logic o_respawn,
	output dino_pkg::speed_t o_speed,
	output dino_pkg::score_t o_score,
	output dino_pkg::score_t o_high_score
);

	localparam dino_pkg::xpos_t X_HOME = dino_pkg::xpos_t'(`SCREEN_W - `OBS_SIZE);
	localparam dino_pkg::xpos_t X_PLAYER = dino_pkg::xpos_t'(`PLAYER_X);
	localparam logic [9:0] PL_LEFT = 10'(`PLAYER_X + `PLAYER_HB_X_OFS);
	localparam logic [9:0] PL_RIGHT = PL_LEFT + 10'(`PLAYER_HB_W);

	logic [8:0] pl_top;
	logic [8:0] pl_bottom;
	logic [9:0] obs_left;
	logic [9:0] obs_right;
	logic [8:0] obs_top;
	logic [8:0] obs_bottom;
	logic collision;
	logic prev_collision;
	dino_pkg::xpos_t prev_x;
	logic armed;    // One score per pass
	logic crossing;
	logic scored;

	// Player column is fixed, ducking lowers and shortens the box
	assign pl_top = {1'b0, hb.player_y} + 9'(`PLAYER_HB_TOP(hb.ducking));
	assign pl_bottom = pl_top + 9'(`PLAYER_HB_H(hb.ducking));

	assign obs_left = {1'b0, hb.obstacle_x};
	assign obs_right = obs_left + 10'(`OBS_SIZE);
	assign obs_top = {1'b0, hb.obstacle_y};
	assign obs_bottom = obs_top + 9'(`OBS_SIZE);

	// Touching edges count as a hit
	assign collision = (PL_RIGHT >= obs_left) && (PL_LEFT <= obs_right) &&
		(pl_bottom >= obs_top) && (pl_top <= obs_bottom);

	assign crossing = (prev_x > X_PLAYER) && (hb.obstacle_x <= X_PLAYER);
	assign scored = crossing && armed && !collision && !prev_collision && !o_game_over;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			o_game_over <= 1'b0;
			o_respawn <= 1'b0;
			o_speed <= '0;
			o_score <= '0;
			o_high_score <= '0;
			prev_collision <= 1'b0;
			prev_x <= X_HOME;
			armed <= 1'b1;
		end else begin
			prev_collision <= collision;
			prev_x <= hb.obstacle_x;
			o_respawn <= scored;

			if (crossing)
				armed <= 1'b0;
			else if (hb.obstacle_x > prev_x)
				armed <= 1'b1;    // Back on the right after wrap or respawn

			if (o_game_over) begin
				if (i_restart) begin
					o_game_over <= 1'b0;
					o_score <= '0;
					o_speed <= '0;
				end
			end else if (collision) begin
				o_game_over <= 1'b1;
				if (o_score > o_high_score)
					o_high_score <= o_score;
			end else if (scored) begin
				o_score <= o_score + 1'b1;
				o_speed <= o_speed + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== game/obstacle_mover.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dino_defines.svh"

module obstacle_mover (
	input  wire Clock,
	input  wire rst_n,
	input  wire dino_pkg::speed_t i_speed,
	input  wire i_respawn,
	input  wire i_game_over,
	hitbox_if.obstacle hb
);

	localparam int STEP_W = $clog2(`OBS_STEP_CYCLES) + 1;
	localparam dino_pkg::xpos_t X_HOME = dino_pkg::xpos_t'(`SCREEN_W - `OBS_SIZE);

	logic [STEP_W-1:0] step_cnt;
	logic [STEP_W-1:0] step_len;
	logic [2:0] step_shift;
	logic step;
	logic [1:0] step_px;
	logic [15:0] lfsr;
	dino_pkg::xpos_t pos_x;
	dino_pkg::ypos_t pos_y;

	// Step period halves per level up to level 4
	assign step_shift = (i_speed > 8'd4) ? 3'd4 : i_speed[2:0];
	assign step_len = STEP_W'(`OBS_STEP_CYCLES) >> step_shift;
	assign step = (step_cnt >= step_len - 1'b1);
	assign step_px = (i_speed <= 8'd5) ? 2'd1 : (i_speed <= 8'd10) ? 2'd2 : 2'd3;

	// Taps 16, 15, 13, 4
	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= 16'hACE1;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || i_game_over) begin
			step_cnt <= '0;
			pos_x <= X_HOME;
			pos_y <= dino_pkg::ypos_t'(`OBS_Y_HIGH);
		end else begin
			if (step)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;

			if (i_respawn) begin
				pos_x <= X_HOME + dino_pkg::xpos_t'(lfsr % 16'(`OBS_SPAWN_SPREAD));
				pos_y <= lfsr[10] ? dino_pkg::ypos_t'(`OBS_Y_LOW)
					: dino_pkg::ypos_t'(`OBS_Y_HIGH);
			end else if (step) begin
				if (pos_x <= dino_pkg::xpos_t'(step_px))
					pos_x <= X_HOME;    // Wrap before the left edge
				else
					pos_x <= pos_x - dino_pkg::xpos_t'(step_px);
			end
		end
	end

	assign hb.obstacle_x = pos_x;
	assign hb.obstacle_y = pos_y;

endmodule

`default_nettype wire

// ==== game/runner_physics.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dino_defines.svh"

module runner_physics (
	input  wire Clock,
	input  wire rst_n,
	input  wire i_jump,
	input  wire i_duck,
	input  wire i_game_over,
	hitbox_if.player hb
);

	localparam int TICK_W = $clog2(`GAME_TICK_CYCLES);
	localparam int DUCK_W = $clog2(`DUCK_TICKS + 1);
	localparam logic signed [9:0] GROUND_S = 10'(`GROUND_Y);
	localparam logic signed [7:0] JUMP_V = 8'(-`JUMP_FORCE);
	localparam logic signed [7:0] GRAV_V = 8'(`GRAVITY);

	logic [TICK_W-1:0] tick_cnt;
	logic game_tick;
	dino_pkg::jump_state_e state;
	logic signed [7:0] velocity;    // Negative moves up
	logic signed [7:0] vel_next;
	dino_pkg::ypos_t pos_y;
	logic signed [9:0] next_y;
	logic [DUCK_W-1:0] duck_left;    // Game ticks of duck still to go
	logic grounded;

	always_ff @(posedge Clock) begin
		if (!rst_n || game_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign game_tick = (tick_cnt == TICK_W'(`GAME_TICK_CYCLES - 1));

	assign grounded = (state == dino_pkg::RUNNING) && (duck_left == '0);
	assign vel_next = velocity + GRAV_V;
	assign next_y = $signed({2'b00, pos_y}) + 10'(velocity);

	always_ff @(posedge Clock) begin
		if (!rst_n || i_game_over) begin
			state <= dino_pkg::RUNNING;
			velocity <= 8'sd0;
			pos_y <= dino_pkg::ypos_t'(`GROUND_Y);
			duck_left <= '0;
		end else begin
			// A duck wins over a jump in the same cycle
			if (i_duck && grounded)
				duck_left <= DUCK_W'(`DUCK_TICKS);
			else if (game_tick && duck_left != '0)
				duck_left <= duck_left - 1'b1;

			case (state)
				dino_pkg::RUNNING: begin
					if (i_jump && !i_duck && grounded) begin
						state <= dino_pkg::ASCENDING;
						velocity <= JUMP_V;
					end
				end
				default: begin    // Airborne
					if (game_tick) begin
						if (next_y >= GROUND_S) begin
							state <= dino_pkg::RUNNING;    // Landed, clamp to ground
							velocity <= 8'sd0;
							pos_y <= dino_pkg::ypos_t'(`GROUND_Y);
						end else begin
							pos_y <= dino_pkg::ypos_t'(next_y);
							velocity <= vel_next;
							if (state == dino_pkg::ASCENDING && !vel_next[7])
								state <= dino_pkg::DESCENDING;
						end
					end
				end
			endcase
		end
	end

	assign hb.player_y = pos_y;
	assign hb.ducking = (duck_left != '0);

endmodule

`default_nettype wire

// ==== hdl/cmd_input.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dino_defines.svh"

module cmd_input (
	input  wire  i_clk,
	input  wire  i_rst_n,
	input  wire  i_uart_rx,
	input  wire  i_key_jump,    // Pressed is high
	input  wire  i_key_duck,
	output logic o_jump,
	output logic o_duck,
	output logic o_restart,
	output logic o_cmd_jump,
	output logic o_cmd_duck
);

	localparam int OS_W = $clog2(`UART_OS_DIV);

	logic [1:0] jump_sync;
	logic [1:0] duck_sync;
	logic [1:0] rx_sync;
	logic [OS_W-1:0] os_div;
	logic os_tick;
	dino_pkg::rx_state_e rx_state;
	logic [3:0] os_cnt;
	logic [2:0] bit_idx;
	logic [7:0] rx_shift;
	logic rx_valid;

	// Two-flop synchronizers, the serial line idles high
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			jump_sync <= 2'b00;
			duck_sync <= 2'b00;
			rx_sync <= 2'b11;
		end else begin
			jump_sync <= {jump_sync[0], i_key_jump};
			duck_sync <= {duck_sync[0], i_key_duck};
			rx_sync <= {rx_sync[0], i_uart_rx};
		end
	end

	// 16x oversampling tick
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			os_div <= '0;
			os_tick <= 1'b0;
		end else if (os_div == OS_W'(`UART_OS_DIV - 1)) begin
			os_div <= '0;
			os_tick <= 1'b1;
		end else begin
			os_div <= os_div + 1'b1;
			os_tick <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rx_state <= dino_pkg::RX_IDLE;
			os_cnt <= 4'd0;
			bit_idx <= 3'd0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (os_tick) begin
				case (rx_state)
					dino_pkg::RX_IDLE: begin
						if (!rx_sync[1]) begin
							rx_state <= dino_pkg::RX_START;
							os_cnt <= 4'd7;    // Half a bit to the middle of start
						end
					end
					dino_pkg::RX_START: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 4'd1;
						end else if (rx_sync[1]) begin
							rx_state <= dino_pkg::RX_IDLE;    // Glitch, not a start bit
						end else begin
							rx_state <= dino_pkg::RX_DATA;
							os_cnt <= 4'd15;
							bit_idx <= 3'd0;
						end
					end
					dino_pkg::RX_DATA: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 4'd1;
						end else begin
							os_cnt <= 4'd15;
							bit_idx <= bit_idx + 3'd1;
							if (bit_idx == 3'd7)
								rx_state <= dino_pkg::RX_STOP;
						end
					end
					default: begin
						if (os_cnt != 4'd0) begin
							os_cnt <= os_cnt - 4'd1;
						end else begin
							rx_valid <= rx_sync[1];    // Framing error drops the byte
							rx_state <= dino_pkg::RX_IDLE;
						end
					end
				endcase
			end
		end
	end

	// LSB first, sampled mid-bit
	always_ff @(posedge i_clk) begin
		if (os_tick && rx_state == dino_pkg::RX_DATA && os_cnt == 4'd0)
			rx_shift <= {rx_sync[1], rx_shift[7:1]};
	end

	assign o_cmd_jump = rx_valid && (rx_shift == `CMD_JUMP);
	assign o_cmd_duck = rx_valid && (rx_shift == `CMD_DUCK);
	assign o_restart = rx_valid && (rx_shift == `CMD_RESTART);

	// Key level or serial command
	assign o_jump = o_cmd_jump | jump_sync[1];
	assign o_duck = o_cmd_duck | duck_sync[1];

endmodule

`default_nettype wire

// ==== hdl/dino_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dino_game_top (
	input  wire Clock,
	input  wire rst_n,
	input  wire i_uart_rx,
	input  wire i_key_jump,
	input  wire i_key_duck,
	output wire dino_pkg::seg7_t o_hex0,
	output wire dino_pkg::seg7_t o_hex1,
	output wire dino_pkg::seg7_t o_hex2,
	output wire dino_pkg::seg7_t o_hex3,
	output wire dino_pkg::seg7_t o_hex4,
	output wire dino_pkg::seg7_t o_hex5,
	output wire o_game_over,
	output wire o_led_jump,
	output wire o_led_duck,
	output wire o_led_restart,    // Also the restart strobe
	output wire dino_pkg::ypos_t o_player_y,
	output wire dino_pkg::xpos_t o_obstacle_x,
	output wire dino_pkg::ypos_t o_obstacle_y
);

	wire jump;
	wire duck;
	wire respawn;
	wire dino_pkg::speed_t speed_level;
	wire dino_pkg::score_t score;
	wire dino_pkg::score_t high_score;

	hitbox_if hb_bus ();

	cmd_input u_cmd_input (
		.i_clk      (Clock),
		.i_rst_n    (rst_n),
		.i_uart_rx  (i_uart_rx),
		.i_key_jump (i_key_jump),
		.i_key_duck (i_key_duck),
		.o_jump     (jump),
		.o_duck     (duck),
		.o_restart  (o_led_restart),
		.o_cmd_jump (o_led_jump),
		.o_cmd_duck (o_led_duck)
	);

	runner_physics u_runner_physics (
		.Clock       (Clock),
		.rst_n       (rst_n),
		.i_jump      (jump),
		.i_duck      (duck),
		.i_game_over (o_game_over),
		.hb          (hb_bus.player)
	);

	obstacle_mover u_obstacle_mover (
		.Clock       (Clock),
		.rst_n       (rst_n),
		.i_speed     (speed_level),
		.i_respawn   (respawn),
		.i_game_over (o_game_over),
		.hb          (hb_bus.obstacle)
	);

	collision_score u_collision_score (
		.Clock        (Clock),
		.rst_n        (rst_n),
		.i_restart    (o_led_restart),
		.hb           (hb_bus.judge),
		.o_game_over  (o_game_over),
		.o_respawn    (respawn),
		.o_speed      (speed_level),
		.o_score      (score),
		.o_high_score (high_score)
	);

	score_display u_score_display (
		.i_score      (score),
		.i_high_score (high_score),
		.o_hex0       (o_hex0),
		.o_hex1       (o_hex1),
		.o_hex2       (o_hex2),
		.o_hex3       (o_hex3),
		.o_hex4       (o_hex4),
		.o_hex5       (o_hex5)
	);

	// Positions for the drawing logic outside this core
	assign o_player_y = hb_bus.player_y;
	assign o_obstacle_x = hb_bus.obstacle_x;
	assign o_obstacle_y = hb_bus.obstacle_y;

endmodule

`default_nettype wire

// ==== hdl/score_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_display (
	input  wire dino_pkg::score_t i_score,
	input  wire dino_pkg::score_t i_high_score,
	output dino_pkg::seg7_t o_hex0,    // Score ones
	output dino_pkg::seg7_t o_hex1,
	output dino_pkg::seg7_t o_hex2,
	output dino_pkg::seg7_t o_hex3,    // High score ones
	output dino_pkg::seg7_t o_hex4,
	output dino_pkg::seg7_t o_hex5
);

	function automatic logic [3:0] digit_of(input dino_pkg::score_t value,
		input int unsigned place);
		return 4'((value / place) % 10);
	endfunction

	function automatic dino_pkg::seg7_t seg7(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;    // Blank
		endcase
	endfunction

	assign o_hex0 = seg7(digit_of(i_score, 1));
	assign o_hex1 = seg7(digit_of(i_score, 10));
	assign o_hex2 = seg7(digit_of(i_score, 100));
	assign o_hex3 = seg7(digit_of(i_high_score, 1));
	assign o_hex4 = seg7(digit_of(i_high_score, 10));
	assign o_hex5 = seg7(digit_of(i_high_score, 100));

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/dino_pkg.sv
common/hitbox_if.sv
hdl/cmd_input.sv
game/runner_physics.sv
game/obstacle_mover.sv
game/collision_score.sv
hdl/score_display.sv
hdl/dino_game_top.sv
dv/dino_game_assert.sv
dv/dino_game_tb.sv
